// File: logic/transform_cfg.svh
`ifndef TRANSFORM_CFG_SVH
`define TRANSFORM_CFG_SVH

// Transform length, power of two
`define POINTS 8
`define POINTS_LOG 3

// Widths
`define SAMPLE_BITS 16
`define TWIDDLE_FRAC 14
`define DATA_BITS (2 * `SAMPLE_BITS)
`define ADDR_BITS 8

// Register map, byte addresses
`define REG_CONTROL 8'h00
`define REG_STATUS 8'h04
`define SAMPLE_BASE 8'h40
`define RESULT_BASE 8'h80

// AXI response codes
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

// File: logic/transformPkg.sv
`include "transform_cfg.svh"

package transformPkg;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // One real or imaginary part
    typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

    // Exact sum of POINTS complex products
    typedef logic signed [`SAMPLE_BITS+`TWIDDLE_FRAC+`POINTS_LOG+1:0] accum_t;

    // Twiddle factor, unity is 2^TWIDDLE_FRAC
    typedef logic signed [`TWIDDLE_FRAC+1:0] twiddle_t;

    typedef logic [`POINTS_LOG-1:0] index_t;

    ////////////////////////////////////////////////////////////
    // Control types
    ////////////////////////////////////////////////////////////

    typedef enum logic { MODE_FWD = 1'b0, MODE_INV = 1'b1 } mode_t;

    typedef enum logic [1:0] { IDLE, RUN, WAIT, DONE } seqState_t;

endpackage

// File: logic/hostWritePort.sv
`include "transform_cfg.svh"

module hostWritePort import transformPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    input  logic [`ADDR_BITS-1:0] awaddr,
    input  logic                  wvalid,
    input  logic [`DATA_BITS-1:0] wdata,
    input  logic                  bready,
    input  logic                  busy,
    input  index_t                sampleAddr,
    output logic                  awready,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    output logic                  startReq,
    output mode_t                 startMode,
    output logic [`DATA_BITS-1:0] sampleData
);

    localparam int WORD_SPAN = `POINTS_LOG + 2;
    localparam logic [`ADDR_BITS-1:0] SAMPLE_BASE_ADDR = `SAMPLE_BASE;

    logic [`DATA_BITS-1:0] mem [`POINTS];
    logic addrReady;
    logic doWrite;
    logic isControl;
    logic isSample;
    logic memWrite;
    index_t wordIdx;

    assign awready = addrReady;
    assign wready = addrReady;
    assign doWrite = addrReady & awvalid & wvalid;

    // Address decode
    assign isControl = awaddr == `REG_CONTROL;
    assign isSample = (awaddr[`ADDR_BITS-1:WORD_SPAN] == SAMPLE_BASE_ADDR[`ADDR_BITS-1:WORD_SPAN])
                      && (awaddr[1:0] == 2'b00);
    assign wordIdx = awaddr[WORD_SPAN-1:2];
    assign memWrite = doWrite & isSample & ~busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addrReady <= 1'b0;
            bvalid <= 1'b0;
            bresp <= `RESP_OKAY;
            startReq <= 1'b0;
            startMode <= MODE_FWD;
        end else begin
            startReq <= 1'b0;
            // Single-cycle ready once address and data are both present
            addrReady <= awvalid & wvalid & ~bvalid & ~addrReady;
            if (doWrite) begin
                bvalid <= 1'b1;
                bresp <= `RESP_SLVERR;
                if (isControl && !(busy && wdata[0])) begin
                    bresp <= `RESP_OKAY;
                    startReq <= wdata[0];
                    startMode <= mode_t'(wdata[1]);
                end else if (isSample && !busy) begin
                    bresp <= `RESP_OKAY;
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Sample memory, registered read for the engine
    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[wordIdx] <= wdata;
        end
        sampleData <= mem[sampleAddr];
    end

    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

endmodule

// File: logic/sequencer.sv
`include "transform_cfg.svh"

module sequencer import transformPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  startReq,
    input  mode_t startMode,
    input  logic  engineDone,
    output logic  busy,
    output logic  done,
    output logic  engineStart,
    output mode_t mode
);

    seqState_t state;
    seqState_t nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (startReq) begin
                    nextState = RUN;
                end
            end
            // Engine kicked off here
            RUN: begin
                nextState = WAIT;
            end
            WAIT: begin
                if (engineDone) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // Mode held for the whole run, done sticky until next start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= MODE_FWD;
            done <= 1'b0;
        end else if (state == IDLE && startReq) begin
            mode <= startMode;
            done <= 1'b0;
        end else if (state == DONE) begin
            done <= 1'b1;
        end
    end

    assign busy = state != IDLE;
    assign engineStart = state == RUN;

    // Engine completion only expected while waiting on it
    assert property (@(posedge clk) disable iff (rst)
        engineDone |-> state == WAIT)
        else $error("engine finished outside of a run");

    // Host port filters starts during a run
    assert property (@(posedge clk) disable iff (rst)
        startReq |-> !busy)
        else $error("start request reached sequencer while busy");

endmodule

// File: logic/dftEngine.sv
`include "transform_cfg.svh"

module dftEngine import transformPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  engineStart,
    input  mode_t                 mode,
    input  logic [`DATA_BITS-1:0] sampleData,
    output index_t                sampleAddr,
    output logic                  binValid,
    output index_t                binIndex,
    output sample_t               binReal,
    output sample_t               binImag,
    output logic                  engineDone
);

    typedef twiddle_t twTable_t [`POINTS];

    localparam real PI = 3.14159265358979323846;

    // cos or sin of 2*pi*m/POINTS, rounded to nearest
    function automatic twTable_t buildTable(input bit sine);
        twTable_t t;
        real angle;
        real v;
        for (int m = 0; m < `POINTS; m++) begin
            angle = 2.0 * PI * m / `POINTS;
            v = (sine ? $sin(angle) : $cos(angle)) * (2.0 ** `TWIDDLE_FRAC);
            t[m] = twiddle_t'($rtoi(v >= 0.0 ? v + 0.5 : v - 0.5));
        end
        return t;
    endfunction

    localparam twTable_t TW_COS = buildTable(1'b0);
    localparam twTable_t TW_SIN = buildTable(1'b1);
    localparam logic [`POINTS_LOG:0] LAST_STEP = `POINTS + 1;
    localparam int FWD_SHIFT = `TWIDDLE_FRAC;
    localparam int INV_SHIFT = `TWIDDLE_FRAC + `POINTS_LOG;
    localparam accum_t SAT_MAX = accum_t'((1 << (`SAMPLE_BITS - 1)) - 1);
    localparam accum_t SAT_MIN = -SAT_MAX - 1;

    function automatic sample_t saturate(input accum_t v);
        if (v > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end else if (v < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(v);
    endfunction

    logic running;
    logic [`POINTS_LOG:0] step;
    index_t bin;
    index_t nIdx;
    index_t twIdx;
    sample_t xRe;
    sample_t xIm;
    twiddle_t wRe;
    twiddle_t wIm;
    accum_t prodRe, prodIm, accRe, accIm;
    accum_t sumRe, sumIm, scaledRe, scaledIm;

    // Step 0 doubles as the start cycle, address 0 already out
    assign sampleAddr = step[`POINTS_LOG-1:0];
    assign xRe = sampleData[`SAMPLE_BITS-1:0];
    assign xIm = sampleData[`DATA_BITS-1:`SAMPLE_BITS];

    // Data in hand belongs to the previous address
    assign nIdx = step[`POINTS_LOG-1:0] - 1'b1;
    assign twIdx = index_t'(nIdx * bin);
    assign wRe = TW_COS[twIdx];
    assign wIm = (mode == MODE_INV) ? TW_SIN[twIdx] : -TW_SIN[twIdx];

    assign sumRe = accRe + prodRe;
    assign sumIm = accIm + prodIm;
    assign scaledRe = (mode == MODE_INV) ? (sumRe >>> INV_SHIFT) : (sumRe >>> FWD_SHIFT);
    assign scaledIm = (mode == MODE_INV) ? (sumIm >>> INV_SHIFT) : (sumIm >>> FWD_SHIFT);

    ////////////////////////////////////////////////////////////
    // Bin and point counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            step <= '0;
            bin <= '0;
            binValid <= 1'b0;
            engineDone <= 1'b0;
        end else begin
            binValid <= 1'b0;
            engineDone <= 1'b0;
            if (engineStart) begin
                running <= 1'b1;
                step <= 1;
                bin <= '0;
            end else if (running) begin
                if (step == LAST_STEP) begin
                    step <= '0;
                    binValid <= 1'b1;
                    bin <= bin + 1'b1;
                    if (bin == index_t'(`POINTS - 1)) begin
                        running <= 1'b0;
                        engineDone <= 1'b1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Multiply, accumulate, scale
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        prodRe <= xRe * wRe - xIm * wIm;
        prodIm <= xRe * wIm + xIm * wRe;
        // Cleared as the first product is formed
        if (step == 1) begin
            accRe <= '0;
            accIm <= '0;
        end else begin
            accRe <= sumRe;
            accIm <= sumIm;
        end
        if (step == LAST_STEP) begin
            binIndex <= bin;
            binReal <= saturate(scaledRe);
            binImag <= saturate(scaledIm);
        end
    end

    // A new run only starts once the previous one has ended
    assert property (@(posedge clk) disable iff (rst)
        engineStart |-> !running)
        else $error("engine restarted in the middle of a run");

endmodule

// File: logic/resultReadPort.sv
`include "transform_cfg.svh"

module resultReadPort import transformPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arvalid,
    input  logic [`ADDR_BITS-1:0] araddr,
    input  logic                  rready,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  binValid,
    input  index_t                binIndex,
    input  sample_t               binReal,
    input  sample_t               binImag,
    output logic                  arready,
    output logic                  rvalid,
    output logic [`DATA_BITS-1:0] rdata,
    output logic [1:0]            rresp
);

    localparam int WORD_SPAN = `POINTS_LOG + 2;
    localparam logic [`ADDR_BITS-1:0] RESULT_BASE_ADDR = `RESULT_BASE;

    logic [`DATA_BITS-1:0] resultMem [`POINTS];
    logic doRead;
    logic isStatus;
    logic isResult;
    index_t wordIdx;

    assign doRead = arvalid & arready;
    assign isStatus = araddr == `REG_STATUS;
    assign isResult = (araddr[`ADDR_BITS-1:WORD_SPAN] == RESULT_BASE_ADDR[`ADDR_BITS-1:WORD_SPAN])
                      && (araddr[1:0] == 2'b00);
    assign wordIdx = araddr[WORD_SPAN-1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            // Held response blocks the next address
            arready <= arvalid & ~rvalid & ~arready;
            if (doRead) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Result buffer and read data
    always_ff @(posedge clk) begin
        if (binValid) begin
            resultMem[binIndex] <= {binImag, binReal};
        end
        if (doRead) begin
            rresp <= `RESP_OKAY;
            if (isStatus) begin
                rdata <= {{(`DATA_BITS - 2){1'b0}}, done, busy};
            end else if (isResult) begin
                rdata <= resultMem[wordIdx];
            end else begin
                rdata <= '0;
                rresp <= `RESP_SLVERR;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read response dropped or changed before rready");

endmodule

// File: logic/transformTop.sv
`include "transform_cfg.svh"

module transformTop import transformPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    input  logic [`ADDR_BITS-1:0] awaddr,
    input  logic                  wvalid,
    input  logic [`DATA_BITS-1:0] wdata,
    input  logic                  bready,
    input  logic                  arvalid,
    input  logic [`ADDR_BITS-1:0] araddr,
    input  logic                  rready,
    output logic                  awready,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    output logic                  arready,
    output logic                  rvalid,
    output logic [`DATA_BITS-1:0] rdata,
    output logic [1:0]            rresp
);

    ////////////////////////////////////////////////////////////
    // Internal connections
    ////////////////////////////////////////////////////////////
    logic startReq;
    mode_t startMode;
    logic busy;
    logic done;
    logic engineStart;
    mode_t mode;
    logic engineDone;
    index_t sampleAddr;
    logic [`DATA_BITS-1:0] sampleData;
    logic binValid;
    index_t binIndex;
    sample_t binReal;
    sample_t binImag;

    hostWritePort i_hostWritePort (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .bready(bready), .busy(busy), .sampleAddr(sampleAddr),
        .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
        .startReq(startReq), .startMode(startMode), .sampleData(sampleData)
    );

    sequencer i_sequencer (
        .clk(clk), .rst(rst),
        .startReq(startReq), .startMode(startMode), .engineDone(engineDone),
        .busy(busy), .done(done), .engineStart(engineStart), .mode(mode)
    );

    dftEngine i_dftEngine (
        .clk(clk), .rst(rst),
        .engineStart(engineStart), .mode(mode), .sampleData(sampleData),
        .sampleAddr(sampleAddr), .binValid(binValid), .binIndex(binIndex),
        .binReal(binReal), .binImag(binImag), .engineDone(engineDone)
    );

    resultReadPort i_resultReadPort (
        .clk(clk), .rst(rst),
        .arvalid(arvalid), .araddr(araddr), .rready(rready),
        .busy(busy), .done(done),
        .binValid(binValid), .binIndex(binIndex), .binReal(binReal), .binImag(binImag),
        .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp)
    );

endmodule

// File: bench/transformTb.sv
`include "transform_cfg.svh"

module transformTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TRANSFORMS = 4;
    localparam int BUS_OPS = 200;
    localparam int BUS_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = 10 + TRANSFORMS * `POINTS * (`POINTS + 2)
                                     + BUS_OPS * BUS_CYCLES + 500;
    localparam real PI = 3.14159265358979323846;

    logic clk;
    logic rst;
    logic awvalid;
    logic [`ADDR_BITS-1:0] awaddr;
    logic wvalid;
    logic [`DATA_BITS-1:0] wdata;
    logic bready;
    logic arvalid;
    logic [`ADDR_BITS-1:0] araddr;
    logic rready;
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [`DATA_BITS-1:0] rdata;
    logic [1:0] rresp;

    logic [`DATA_BITS-1:0] samples [`POINTS];
    logic [`DATA_BITS-1:0] expected [`POINTS];
    logic [31:0] lfsrState = 32'hdf01_fcec;
    int checks = 0;
    int errors = 0;

    transformTop i_transformTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Responses hold still under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            errors++;
            $display("write response dropped or changed while bready was low");
        end

    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            errors++;
            $display("read response dropped or changed while rready was low");
        end

    ////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = stepLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [`SAMPLE_BITS-1:0] clampPart(input longint v);
        longint hi;
        hi = (longint'(1) <<< (`SAMPLE_BITS - 1)) - 1;
        if (v > hi) begin
            v = hi;
        end else if (v < -hi - 1) begin
            v = -hi - 1;
        end
        return v[`SAMPLE_BITS-1:0];
    endfunction

    function automatic void modelBins(input bit inverse);
        longint sumRe;
        longint sumIm;
        longint wr;
        longint wi;
        longint xr;
        longint xi;
        real angle;
        for (int k = 0; k < `POINTS; k++) begin
            sumRe = 0;
            sumIm = 0;
            for (int n = 0; n < `POINTS; n++) begin
                angle = 2.0 * PI * ((n * k) % `POINTS) / `POINTS;
                // Real to integer cast rounds to nearest
                wr = longint'($cos(angle) * (2.0 ** `TWIDDLE_FRAC));
                wi = longint'($sin(angle) * (2.0 ** `TWIDDLE_FRAC));
                if (!inverse) begin
                    wi = -wi;
                end
                xr = longint'($signed(samples[n][`SAMPLE_BITS-1:0]));
                xi = longint'($signed(samples[n][`DATA_BITS-1:`SAMPLE_BITS]));
                sumRe += xr * wr - xi * wi;
                sumIm += xr * wi + xi * wr;
            end
            sumRe = sumRe >>> (inverse ? `TWIDDLE_FRAC + `POINTS_LOG : `TWIDDLE_FRAC);
            sumIm = sumIm >>> (inverse ? `TWIDDLE_FRAC + `POINTS_LOG : `TWIDDLE_FRAC);
            expected[k] = {clampPart(sumIm), clampPart(sumRe)};
        end
    endfunction

    function automatic logic [`ADDR_BITS-1:0] wordAddr(input logic [`ADDR_BITS-1:0] base,
                                                        input int idx);
        return base + idx * 4;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus tasks and checks
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [`DATA_BITS-1:0] expectedValue,
                              input logic [`DATA_BITS-1:0] actual);
        checks++;
        assert (actual === expectedValue)
        else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expectedValue, actual);
        end
    endtask

    // gap is the number of cycles bready stays low
    task automatic writeWord(input logic [`ADDR_BITS-1:0] addr,
                             input logic [`DATA_BITS-1:0] data, input int gap,
                             output logic [1:0] resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        bready = 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        #1;
        bready = 1'b0;
    endtask

    task automatic readWord(input logic [`ADDR_BITS-1:0] addr, input int gap,
                            output logic [`DATA_BITS-1:0] data, output logic [1:0] resp);
        araddr = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        #1;
        arvalid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        rready = 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        #1;
        rready = 1'b0;
    endtask

    task automatic loadSamples(input string testName);
        logic [1:0] resp;
        for (int n = 0; n < `POINTS; n++) begin
            writeWord(wordAddr(`SAMPLE_BASE, n), samples[n], randBits(2), resp);
            checkValue($sformatf("%s sample %0d resp", testName, n), `RESP_OKAY, resp);
        end
    endtask

    task automatic startTransform(input string testName, input bit inverse);
        logic [1:0] resp;
        writeWord(`REG_CONTROL, {{(`DATA_BITS - 2){1'b0}}, inverse, 1'b1}, 0, resp);
        checkValue({testName, " start resp"}, `RESP_OKAY, resp);
    endtask

    task automatic waitDone(input string testName);
        logic [`DATA_BITS-1:0] status;
        logic [1:0] resp;
        status = '0;
        while (!status[1]) begin
            readWord(`REG_STATUS, 0, status, resp);
        end
        checkValue({testName, " status"}, 2, status);
        checkValue({testName, " status resp"}, `RESP_OKAY, resp);
    endtask

    task automatic compareResults(input string testName);
        logic [`DATA_BITS-1:0] data;
        logic [1:0] resp;
        for (int k = 0; k < `POINTS; k++) begin
            readWord(wordAddr(`RESULT_BASE, k), randBits(3), data, resp);
            checkValue($sformatf("%s bin %0d resp", testName, k), `RESP_OKAY, resp);
            checkValue($sformatf("%s bin %0d", testName, k), expected[k], data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [`DATA_BITS-1:0] data;
        logic [1:0] resp;
        logic [`SAMPLE_BITS-1:0] partRe;
        logic [`SAMPLE_BITS-1:0] partIm;
        real angle;
        rst = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("reset valids", 0, {awready, wready, bvalid, arready, rvalid});
        readWord(`REG_STATUS, 0, data, resp);
        checkValue("reset status", 0, data);
        checkValue("reset status resp", `RESP_OKAY, resp);

        for (int n = 0; n < `POINTS; n++) begin
            samples[n] = randBits(32);
        end
        loadSamples("forward");
        startTransform("forward", 1'b0);
        waitDone("forward");
        modelBins(1'b0);
        compareResults("forward");

        // Same samples, inverse
        startTransform("inverse", 1'b1);
        waitDone("inverse");
        modelBins(1'b1);
        compareResults("inverse");

        // Writes during a run are refused
        startTransform("busy", 1'b0);
        writeWord(wordAddr(`SAMPLE_BASE, 0), ~samples[0], 0, resp);
        checkValue("busy sample write resp", `RESP_SLVERR, resp);
        writeWord(`REG_CONTROL, 3, 0, resp);
        checkValue("busy control write resp", `RESP_SLVERR, resp);
        waitDone("busy");
        modelBins(1'b0);
        compareResults("busy repeat");

        // Full scale aligned with bin 1 of the inverse
        for (int n = 0; n < `POINTS; n++) begin
            angle = 2.0 * PI * n / `POINTS;
            partRe = ($cos(angle) > -1.0e-9) ? 16'h7fff : 16'h8000;
            partIm = ($sin(angle) > 1.0e-9) ? 16'h8000 : 16'h7fff;
            samples[n] = {partIm, partRe};
        end
        loadSamples("saturation");
        startTransform("saturation", 1'b1);
        waitDone("saturation");
        modelBins(1'b1);
        compareResults("saturation");
        readWord(wordAddr(`RESULT_BASE, 1), 0, data, resp);
        checkValue("saturation bin 1 real", 16'h7fff, data[`SAMPLE_BITS-1:0]);

        writeWord(`REG_STATUS, 1, randBits(2), resp);
        checkValue("unmapped write status resp", `RESP_SLVERR, resp);
        writeWord(8'h60, 1, randBits(2), resp);
        checkValue("unmapped write 0x60 resp", `RESP_SLVERR, resp);
        writeWord(8'h42, 1, randBits(2), resp);
        checkValue("unaligned write resp", `RESP_SLVERR, resp);
        readWord(`REG_CONTROL, randBits(3), data, resp);
        checkValue("unmapped read control resp", `RESP_SLVERR, resp);
        checkValue("unmapped read control data", 0, data);
        readWord(wordAddr(`SAMPLE_BASE, 1), randBits(3), data, resp);
        checkValue("unmapped read sample resp", `RESP_SLVERR, resp);
        checkValue("unmapped read sample data", 0, data);
        readWord(8'hc0, randBits(3), data, resp);
        checkValue("unmapped read 0xc0 resp", `RESP_SLVERR, resp);
        checkValue("unmapped read 0xc0 data", 0, data);
        compareResults("saturation reread");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * 10);
        errors++;
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/transformPkg.sv
logic/hostWritePort.sv
logic/sequencer.sv
logic/dftEngine.sv
logic/resultReadPort.sv
logic/transformTop.sv
bench/transformTb.sv
